// File: uart_pkg.sv
package uart_pkg;

    // serial line timing for 115200 baud from a 50 MHz clock
    localparam int clks_per_bit = 434;
    localparam int half_bit     = 217; // start edge to middle of the start bit

    typedef logic [7:0] uart_byte_t;
    typedef logic [8:0] baud_cnt_t;    // wide enough for clks_per_bit - 1

endpackage

// File: loader_pkg.sv
package loader_pkg;

    typedef logic [31:0] mem_word_t;
    typedef logic [31:0] mem_addr_t;   // byte address

    localparam int load_words     = 8; // words written before done
    localparam int bytes_per_word = 4;

    localparam int fifo_depth = 16;
    typedef logic [4:0] fifo_ptr_t;    // index bits plus one wrap bit

endpackage

// File: uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                rx_valid,
    output logic                frame_error_pulse
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       fall;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift_q;

    // two flop synchronizer, the line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev & ~rx_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= idle;
            baud_cnt          <= '0;
            bit_cnt           <= '0;
            rx_valid          <= 1'b0;
            frame_error_pulse <= 1'b0;
        end else begin
            rx_valid          <= 1'b0;
            frame_error_pulse <= 1'b0;
            case (state)
                idle: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (fall) begin
                        state <= start;
                    end
                end
                start: begin
                    if (baud_cnt == baud_cnt_t'(half_bit - 1)) begin
                        baud_cnt <= '0;
                        if (rx_sync) begin
                            state <= idle; // start bit gone at mid-bit, a glitch
                        end else begin
                            state <= data;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                data: begin
                    if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                stop: begin
                    if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
                        baud_cnt          <= '0;
                        state             <= idle;
                        rx_valid          <= rx_sync;  // good stop bit hands the byte on
                        frame_error_pulse <= ~rx_sync; // low stop bit drops the frame
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == data && baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

    a_valid_xor_error: assert property (
        @(posedge clk) disable iff (rst)
        !(rx_valid && frame_error_pulse)
    );

endmodule

// File: byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t push_byte,
    input  logic                 push,
    output uart_pkg::uart_byte_t fifo_byte,
    output logic                 fifo_valid,
    input  logic                 fifo_ready,
    output logic                 overrun
);

    import uart_pkg::*;
    import loader_pkg::*;

    uart_byte_t mem [fifo_depth];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_ptr_t  count;
    logic       full;
    logic       empty;
    logic       do_push;
    logic       do_pop;

    // same index with opposite wrap bits means the ring is full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(fifo_depth)] != rd_ptr[$clog2(fifo_depth)]) &&
                   (wr_ptr[$clog2(fifo_depth)-1:0] == rd_ptr[$clog2(fifo_depth)-1:0]);
    assign count = wr_ptr - rd_ptr;

    assign do_push = push & ~full;
    assign do_pop  = fifo_valid & fifo_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[$clog2(fifo_depth)-1:0]] <= push_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && full) begin
                overrun <= 1'b1; // the byte is lost, stays set until reset
            end
        end
    end

    assign fifo_valid = ~empty;
    assign fifo_byte  = mem[rd_ptr[$clog2(fifo_depth)-1:0]];

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= fifo_ptr_t'(fifo_depth)
    );

    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_byte)
    );

endmodule

// File: word_packer.sv
`timescale 1ns/100ps

module word_packer (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t fifo_byte,
    input  logic                 fifo_valid,
    output logic                 fifo_ready,
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output loader_pkg::mem_addr_t mem_addr,
    output loader_pkg::mem_word_t mem_data,
    output logic                 done
);

    import loader_pkg::*;

    typedef enum logic [1:0] {
        collect,
        write,
        finished
    } pack_state_t;

    pack_state_t state;
    logic [1:0]  lane;
    mem_word_t   word_q;
    mem_addr_t   addr_q;
    logic        take;
    logic        last_write;

    assign fifo_ready = (state == collect);
    assign take       = fifo_valid & fifo_ready;

    // the address doubles as the word count
    assign last_write = (addr_q == mem_addr_t'((load_words - 1) * bytes_per_word));

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= collect;
            lane   <= '0;
            addr_q <= '0;
        end else begin
            case (state)
                collect: begin
                    if (take) begin
                        lane <= lane + 1'b1;
                        if (lane == 2'(bytes_per_word - 1)) begin
                            state <= write;
                        end
                    end
                end
                write: begin
                    if (mem_ready) begin
                        addr_q <= addr_q + mem_addr_t'(bytes_per_word);
                        state  <= last_write ? finished : collect;
                    end
                end
                finished: begin
                    state <= finished; // held until reset
                end
                default: begin
                    state <= collect;
                end
            endcase
        end
    end

    // first byte lands in the low lane
    always_ff @(posedge clk) begin
        if (take) begin
            word_q[{lane, 3'b000} +: 8] <= fifo_byte;
        end
    end

    assign mem_valid = (state == write);
    assign mem_addr  = addr_q;
    assign mem_data  = word_q;
    assign done      = (state == finished);

    a_write_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data)
    );

endmodule

// File: uart_loader_top.sv
`timescale 1ns/100ps

module uart_loader_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output loader_pkg::mem_addr_t mem_addr,
    output loader_pkg::mem_word_t mem_data,
    output logic                  done,
    output logic                  overrun,
    output logic                  frame_error
);

    import uart_pkg::*;

    uart_byte_t rx_byte;
    logic       rx_valid;
    logic       frame_error_pulse;
    uart_byte_t fifo_byte;
    logic       fifo_valid;
    logic       fifo_ready;

    uart_rx uart_rx_inst (
        .clk               (clk),
        .rst               (rst),
        .rx                (rx),
        .rx_byte           (rx_byte),
        .rx_valid          (rx_valid),
        .frame_error_pulse (frame_error_pulse)
    );

    byte_fifo byte_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .push_byte  (rx_byte),
        .push       (rx_valid),
        .fifo_byte  (fifo_byte),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .overrun    (overrun)
    );

    word_packer word_packer_inst (
        .clk        (clk),
        .rst        (rst),
        .fifo_byte  (fifo_byte),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .done       (done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_error <= 1'b0;
        end else if (frame_error_pulse) begin
            frame_error <= 1'b1; // sticky until reset
        end
    end

endmodule

// File: tb_uart_loader.sv
`timescale 1ns/100ps

module tb_uart_loader;

    import uart_pkg::*;
    import loader_pkg::*;

    logic      clk = 1'b0;
    logic      rst;
    logic      rx;
    logic      mem_valid;
    logic      mem_ready;
    mem_addr_t mem_addr;
    mem_word_t mem_data;
    logic      done;
    logic      overrun;
    logic      frame_error;

    string       lines[$];
    mem_addr_t   exp_addr[$];
    mem_word_t   exp_data[$];
    logic [7:0]  ready_mode = "1";
    logic [31:0] rng_state = 32'haa66_cffd;
    int          test_num = 0;
    int          test_errors = 0;
    int          write_errors = 0;   // counted by the write monitor only
    int          errors_at_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    longint      watchdog_ns = 0;

    uart_loader_top uart_loader_top_inst (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .done        (done),
        .overrun     (overrun),
        .frame_error (frame_error)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory back-pressure follows the scripted ready mode
    initial begin
        mem_ready = 1'b0;
        forever begin
            @(negedge clk);
            rng_state = next_random(rng_state);
            if (ready_mode == "X") begin
                mem_ready = rng_state[0];
            end else begin
                mem_ready = (ready_mode == "1");
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && mem_valid && mem_ready) begin
            if (mem_addr >= mem_addr_t'(load_words * bytes_per_word)) begin
                $display("test %0d: write to %h lies past the load area", test_num, mem_addr);
                write_errors++;
            end
            if (exp_addr.size() == 0) begin
                $display("test %0d: write of %h to %h was not expected", test_num, mem_data,
                         mem_addr);
                write_errors++;
            end else begin
                if (mem_addr !== exp_addr[0]) begin
                    $display("[FAIL] mem_addr expected %h got %h", exp_addr[0], mem_addr);
                    write_errors++;
                end
                if (mem_data !== exp_data[0]) begin
                    $display("[FAIL] mem_data expected %h got %h", exp_data[0], mem_data);
                    write_errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        rx  = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    // start bit, eight data bits lsb first, then the scripted stop bit
    task automatic send_frame(input logic [7:0] value, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        if (!stop_bit) begin
            rx = 1'b1; // line back to idle so the next start bit has a falling edge
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic check_flags(input logic exp_done, input logic exp_over, input logic exp_fe);
        int waited;
        waited = 0;
        while (exp_addr.size() != 0 && waited < 2 * clks_per_bit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_addr.size() != 0) begin
            $display("test %0d: %0d expected writes never happened", test_num, exp_addr.size());
            test_errors++;
            exp_addr.delete();
            exp_data.delete();
        end
        @(negedge clk);
        if (mem_valid !== 1'b0) begin
            $display("[FAIL] mem_valid expected %h got %h", 1'b0, mem_valid);
            test_errors++;
        end
        if (done !== exp_done) begin
            $display("[FAIL] done expected %h got %h", exp_done, done);
            test_errors++;
        end
        if (overrun !== exp_over) begin
            $display("[FAIL] overrun expected %h got %h", exp_over, overrun);
            test_errors++;
        end
        if (frame_error !== exp_fe) begin
            $display("[FAIL] frame_error expected %h got %h", exp_fe, frame_error);
            test_errors++;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          total_bytes;
        int          count;
        int          stop_bit;
        int          f_done;
        int          f_over;
        int          f_fe;
        int          errs;
        logic [7:0]  cmd;
        logic [7:0]  first;
        logic [31:0] addr;
        logic [31:0] data;
        string       line;
        rst = 1'b1;
        rx  = 1'b1;
        total_bytes = 0;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_input.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines.push_back(line);
                if ($sscanf(line, "B %h %d %d", first, count, stop_bit) == 3) begin
                    total_bytes += count;
                end
            end
            $fclose(fd);
        end
        watchdog_ns = longint'(2 * total_bytes * 10 * clks_per_bit * 20) + 64'd1_000_000;
        foreach (lines[i]) begin
            cmd = "#";
            n = $sscanf(lines[i], "%c", cmd);
            case (cmd)
                "T": begin
                    n = $sscanf(lines[i], "T %d", test_num);
                    test_errors = 0;
                    errors_at_start = write_errors;
                end
                "R": apply_reset();
                "M": n = $sscanf(lines[i], "M %c", ready_mode);
                "B": begin
                    n = $sscanf(lines[i], "B %h %d %d", first, count, stop_bit);
                    for (int k = 0; k < count; k++) begin
                        send_frame(8'(first + k), stop_bit[0]);
                    end
                end
                "W": begin
                    n = $sscanf(lines[i], "W %h %h %d", addr, data, count);
                    for (int k = 0; k < count; k++) begin
                        exp_addr.push_back(addr + 32'(k * bytes_per_word));
                        exp_data.push_back(data + 32'(k) * 32'h0404_0404);
                    end
                end
                "F": begin
                    n = $sscanf(lines[i], "F %d %d %d", f_done, f_over, f_fe);
                    check_flags(f_done[0], f_over[0], f_fe[0]);
                end
                "E": begin
                    errs = test_errors + write_errors - errors_at_start;
                    if (errs == 0) begin
                        $display("test %0d passed", test_num);
                        pass_count++;
                    end else begin
                        $display("test %0d failed with %0d errors", test_num, errs);
                        fail_count++;
                    end
                end
                default: ;
            endcase
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog expired before the script finished");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: tb_input.txt
# T test, R reset, M ready mode (1 high, X random, 0 low), B first_byte_hex count stop_bit
# W first_addr_hex first_data_hex count (next words add 4 and 04040404), F done overrun frame_error
T 1
R
F 0 0 0
E
T 2
R
M 1
W 0 03020100 8
B 00 36 1
F 1 0 0
E
T 3
R
M X
W 0 03020100 8
B 00 32 1
F 1 0 0
E
T 4
R
M 1
W 0 43424140 2
B 40 2 1
B 99 1 0
B 42 6 1
F 0 0 1
E
T 5
R
M 0
W 0 53525150 5
W 14 73727170 1
B 50 21 1
M 1
B 70 4 1
F 0 1 0
E

// File: src.f
uart_pkg.sv
loader_pkg.sv
uart_rx.sv
byte_fifo.sv
word_packer.sv
uart_loader_top.sv
tb_uart_loader.sv

// File: Makefile
TOP = tb_uart_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module uart_loader_top

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
